//--- sim.f
fma_pkg.sv
fma_ctrl.sv
fma_mul_align.sv
fma_lead_one.sv
fma_normalizer.sv
fma_rounder.sv
fma_top.sv
tb_fma_checker.sv
tb_fma.sv

//--- Makefile
TOP = tb_fma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_fma.sv
`default_nettype none

module tb_fma import fma_pkg::*; ();

    localparam int N_RAND     = 60;
    localparam int N_CANCEL   = 24;
    localparam int N_SUB      = 24;
    localparam int N_TIE      = 16;
    localparam int N_OVF      = 10;
    localparam int N_BUSY     = 6;
    localparam int N_OPS      = N_RAND + N_CANCEL + N_SUB + N_TIE + N_OVF + N_BUSY;
    localparam int MAX_CYCLES = N_OPS*6 + 100;  // Six cycles per operation, plus reset

    logic        clk   = 1'b0;
    logic        rst_n = 1'b0;
    logic        start;
    float_t      a, b, c, result;
    logic        overflow, busy, done;
    logic [31:0] seed;
    int          cycles = 0;
    int          tests, errors;
    float_t      a_v, b_v, c_v;
    logic [31:0] r;

    fma_top UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .start_i    (start),
        .a_i        (a),
        .b_i        (b),
        .c_i        (c),
        .result_o   (result),
        .overflow_o (overflow),
        .busy_o     (busy),
        .done_o     (done)
    );

    tb_fma_checker u_checker (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .start_i    (start),
        .a_i        (a),
        .b_i        (b),
        .c_i        (c),
        .result_i   (result),
        .overflow_i (overflow),
        .busy_i     (busy),
        .done_i     (done),
        .tests_o    (tests),
        .errors_o   (errors)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;    // Numerical Recipes constants
        return seed;
    endfunction

    // Random sign and fraction, exponent in lo .. lo+span-1
    function automatic float_t rand_float(input int lo, input int span);
        logic [31:0] r1, r2;
        r1 = next_rand();
        r2 = next_rand();
        return {r1[31], 8'(lo + int'(r1[30:23]) % span), r2[31:9]};    // High bits only
    endfunction

    // Close to -(x*y), low fraction bits disturbed
    function automatic float_t near_neg_product(input float_t x, input float_t y);
        logic [47:0] p;
        logic [22:0] f;
        int          e;
        p = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
        e = int'(x[30:23]) + int'(y[30:23]) - 127;
        if (p[47]) begin
            f = p[46:24];
            e = e + 1;
        end else begin
            f = p[45:23];
        end
        f = f ^ 23'(next_rand() >> 29);                 // Zero keeps the rounded product
        return {~(x[31] ^ y[31]), 8'(e), f};
    endfunction

    // One operation; start held for hold extra cycles with new operands while busy
    task automatic run_op(input float_t a_in, input float_t b_in, input float_t c_in,
                          input int hold);
        @(posedge clk);
        start <= 1'b1;
        a     <= a_in;
        b     <= b_in;
        c     <= c_in;
        repeat (hold) begin
            @(posedge clk);
            a <= rand_float(1, 254);                    // Must not reach the result
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!done) @(negedge clk);                   // Bounded by the run limit
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        seed  = 32'h3ec1_819a;
        start = 1'b0;
        a     = '0;
        b     = '0;
        c     = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_RAND; i++) begin         // Plain normals
            a_v = rand_float(64, 128);
            b_v = rand_float(64, 128);
            c_v = rand_float(64, 128);
            run_op(a_v, b_v, c_v, 0);
        end
        for (int i = 0; i < N_CANCEL; i++) begin       // Deep cancellation
            a_v = rand_float(80, 96);
            b_v = rand_float(80, 96);
            c_v = near_neg_product(a_v, b_v);
            if (i % 4 == 0) begin
                b_v = {b_v[31], 8'd127, 23'd0};         // Times one, then exact zero
                c_v = {~(a_v[31] ^ b_v[31]), a_v[30:0]};
            end
            run_op(a_v, b_v, c_v, 0);
        end
        for (int i = 0; i < N_SUB; i++) begin          // Tiny product, subnormal addend
            a_v = rand_float(10, 50);
            b_v = rand_float(107 - int'(a_v[30:23]), 26);
            r   = next_rand();
            c_v = {r[31], 8'd0, r[30:8]};
            if (i % 4 == 1) begin
                c_v[22:0] = '0;                         // Signed zero, bare product shifts right
            end
            run_op(a_v, b_v, c_v, 0);
        end
        for (int i = 0; i < N_TIE; i++) begin          // a*1 plus half an ulp of a
            a_v    = rand_float(40, 160);
            a_v[0] = i[0];                              // Both even and odd LSB
            r      = next_rand();
            b_v    = 32'h3f80_0000;
            c_v    = {r[31], a_v[30:23] - 8'd24, 23'd0};
            run_op(a_v, b_v, c_v, 0);
        end
        for (int i = 0; i < N_OVF; i++) begin
            a_v = rand_float(200, 54);
            b_v = rand_float(200, 54);
            c_v = rand_float(64, 128);
            run_op(a_v, b_v, c_v, 0);
        end
        for (int i = 0; i < N_BUSY; i++) begin         // Start kept high while busy
            a_v = rand_float(64, 128);
            b_v = rand_float(64, 128);
            c_v = rand_float(64, 128);
            run_op(a_v, b_v, c_v, 1 + i % 3);
        end

        repeat (2) @(negedge clk);
        if (tests != N_OPS) begin
            $display("only %0d of %0d operations were checked", tests, N_OPS);
        end
        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0 && tests == N_OPS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_fma_checker.sv
`default_nettype none

module tb_fma_checker import fma_pkg::*; (
    input  wire    clk_i,
    input  wire    rst_n_i,
    input  wire    start_i,
    input  float_t a_i,
    input  float_t b_i,
    input  float_t c_i,
    input  float_t result_i,
    input  wire    overflow_i,
    input  wire    busy_i,
    input  wire    done_i,
    output int     tests_o,
    output int     errors_o
);

    localparam int W = 512;     // Holds any exact product plus addend

    int          n_tests  = 0;
    int          n_errors = 0;
    int          cnt      = 0;  // Cycles left until done
    int          errs;
    logic [32:0] expect_v;      // {overflow, result}
    float_t      a_s, b_s, c_s;
    logic        exp_busy, exp_done;

    assign tests_o  = n_tests;
    assign errors_o = n_errors;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Weight of the fraction LSB
    function automatic int lsb_exp(input float_t f);
        return (f[30:23] == 8'd0) ? -149 : int'(f[30:23]) - 150;
    endfunction

    // Exact a*b+c on wide integers, rounded once to nearest even
    function automatic logic [32:0] fma_ref(input float_t fa, input float_t fb, input float_t fc);
        logic [W-1:0] pm, cm, mag;
        logic [24:0]  m;
        logic         sp, s, guard, sticky;
        int           ep, ec, emin, msb, q, drop;
        sp   = fa[31] ^ fb[31];
        pm   = W'({|fa[30:23], fa[22:0]}) * W'({|fb[30:23], fb[22:0]});
        cm   = W'({|fc[30:23], fc[22:0]});
        ep   = lsb_exp(fa) + lsb_exp(fb);
        ec   = lsb_exp(fc);
        emin = (ep < ec) ? ep : ec;
        pm   = pm << (ep - emin);                   // Common scale
        cm   = cm << (ec - emin);
        if (sp == fc[31]) begin
            mag = pm + cm;
            s   = sp;
        end else if (pm >= cm) begin
            mag = pm - cm;
            s   = sp;
        end else begin
            mag = cm - pm;
            s   = fc[31];
        end
        if (mag == '0) return 33'd0;                // Exact zero is +0
        msb = 0;
        for (int i = 0; i < W; i++) begin
            if (mag[i]) msb = i;
        end
        q = msb + emin - 23;                        // Weight of the result LSB
        if (q < -149) q = -149;                     // Subnormal floor
        drop = q - emin;
        if (drop <= 0) begin
            m = 25'(mag << -drop);                  // Exact, nothing to round
        end else begin
            m      = 25'(mag >> drop);
            guard  = (mag & (W'(1) << (drop - 1))) != '0;
            sticky = (mag << (W + 1 - drop)) != '0;
            m      = m + 25'(guard & (sticky | m[0]));
        end
        if (m[24]) begin                            // Rounded into the next binade
            m = m >> 1;
            q = q + 1;
        end
        if (!m[23]) return {1'b0, s, 8'd0, m[22:0]};
        if (q + 150 >= 255) return {1'b1, s, 8'hff, 23'd0};
        return {1'b0, s, 8'(q + 150), m[22:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("error %s expected %h actual %h", name, exp_v, act_v);
            n_errors = n_errors + 1;
        end
    endtask

    ////////////////////////////////////////
    // Monitor, mid-cycle sampling
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            cnt = 0;
            check_val("result_o", 32'd0, result_i);         // Reset values
            check_val("overflow_o", 32'd0, 32'(overflow_i));
            check_val("busy_o", 32'd0, 32'(busy_i));
            check_val("done_o", 32'd0, 32'(done_i));
        end else begin
            exp_done = (cnt == 1);
            if (cnt != 0) cnt = cnt - 1;
            exp_busy = (cnt != 0);
            check_val("busy_o", 32'(exp_busy), 32'(busy_i));
            check_val("done_o", 32'(exp_done), 32'(done_i));
            if (exp_done) begin
                errs = n_errors;
                check_val("result_o", expect_v[31:0], result_i);
                check_val("overflow_o", 32'(expect_v[32]), 32'(overflow_i));
                n_tests = n_tests + 1;
                $display("test %0d: %h * %h + %h = %h %s", n_tests, a_s, b_s, c_s,
                         result_i, (n_errors == errs) ? "ok" : "mismatch");
            end
            if (start_i && !exp_busy) begin             // Taken at the next edge
                a_s      = a_i;
                b_s      = b_i;
                c_s      = c_i;
                expect_v = fma_ref(a_i, b_i, c_i);
                cnt      = 5;
            end
        end
    end

endmodule

`default_nettype wire

//--- fma_top.sv
`default_nettype none

module fma_top import fma_pkg::*; (
    input  wire    clk_i,
    input  wire    rst_n_i,
    input  wire    start_i,
    input  float_t a_i,
    input  float_t b_i,
    input  float_t c_i,
    output float_t result_o,
    output logic   overflow_o,
    output logic   busy_o,
    output logic   done_o
);

    logic   ld_op, ld_sum, ld_norm, ld_res;
    float_t a_q, b_q, c_q;
    sum_s   sum_d, sum_q;
    shift_t shift_num;
    norm_s  norm_d, norm_q;
    float_t res_d;
    logic   ovf_d;

    fma_ctrl u_ctrl (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (start_i),
        .ld_op_o   (ld_op),
        .ld_sum_o  (ld_sum),
        .ld_norm_o (ld_norm),
        .ld_res_o  (ld_res),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    fma_mul_align u_mul_align (.a_i(a_q), .b_i(b_q), .c_i(c_q), .sum_o(sum_d));

    fma_lead_one u_lead_one (.mant_i(sum_q.mag), .shift_num_o(shift_num));

    fma_normalizer u_norm (.sum_i(sum_q), .shift_num_i(shift_num), .norm_o(norm_d));

    fma_rounder u_round (.norm_i(norm_q), .result_o(res_d), .overflow_o(ovf_d));

    // Stage registers
    always_ff @(posedge clk_i) begin
        if (ld_op) begin
            a_q <= a_i;
            b_q <= b_i;
            c_q <= c_i;
        end
        if (ld_sum)  sum_q  <= sum_d;
        if (ld_norm) norm_q <= norm_d;
    end

    // Result holds until the next operation completes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o   <= '0;
            overflow_o <= 1'b0;
        end else if (ld_res) begin
            result_o   <= res_d;
            overflow_o <= ovf_d;
        end
    end

    // Done comes four edges after an accepted start, seen one edge later
    a_done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(done_o) |-> $past(ld_op, 5) && !busy_o);

endmodule

`default_nettype wire

//--- fma_rounder.sv
`default_nettype none

module fma_rounder import fma_pkg::*; (
    input  norm_s  norm_i,
    output float_t result_o,
    output logic   overflow_o
);

    localparam int EXP_INF = (1 << EXP_W) - 1;  // All ones

    logic              lsb, guard, rnd, up;
    logic [MANT_W+1:0] mant_r;                  // Room for the carry
    logic [MANT_W:0]   mant_f;
    exp_ext_t          exp_r;
    logic              ovf;

    always_comb begin
        lsb   = norm_i.mant[2];                 // Fraction LSB
        guard = norm_i.mant[1];
        rnd   = norm_i.mant[0];
        up    = guard & (rnd | norm_i.sticky | lsb);    // Ties go to even

        mant_r = {1'b0, norm_i.mant[NORM_W-1:2]} + (MANT_W+2)'(up);

        if (mant_r[MANT_W+1]) begin
            mant_f = mant_r[MANT_W+1:1];        // 10.0..0 becomes 1.0..0
            exp_r  = norm_i.exp + exp_ext_t'(1);
        end else begin
            mant_f = mant_r[MANT_W:0];
            exp_r  = norm_i.exp;
        end

        // Exponent never drops below one here
        ovf = !norm_i.is_zero && (exp_r >= exp_ext_t'(EXP_INF));

        if (norm_i.is_zero) begin
            result_o = '0;                      // Exact zero, positive
        end else if (ovf) begin
            result_o = {norm_i.sign, EXP_W'(EXP_INF), MANT_W'(0)};  // Signed infinity
        end else if (mant_f[MANT_W]) begin
            result_o = {norm_i.sign, exp_r[EXP_W-1:0], mant_f[MANT_W-1:0]};
        end else begin
            result_o = {norm_i.sign, EXP_W'(0), mant_f[MANT_W-1:0]};  // Subnormal
        end
        overflow_o = ovf;
    end

endmodule

`default_nettype wire

//--- fma_normalizer.sv
`default_nettype none

module fma_normalizer import fma_pkg::*; (
    input  sum_s   sum_i,
    input  shift_t shift_num_i,
    output norm_s  norm_o
);

    localparam int CUT = WIDE_W - NORM_W;   // Bits below the round bit

    exp_ext_t         e, exp_n;
    logic [EXP_W+1:0] lim;                  // Largest left shift keeping exp >= 1
    logic [EXP_W+1:0] ls_amt, rs_amt;
    wide_mant_t       shifted, rs_mant;
    logic             rs_lost;

    always_comb begin
        e       = sum_i.exp;
        lim     = '0;
        ls_amt  = '0;
        rs_amt  = '0;
        rs_mant = '0;
        rs_lost = 1'b0;

        if (e > 0) begin
            ////////////////////////////////////////
            // Left shift, limited by the exponent
            ////////////////////////////////////////
            lim = e - exp_ext_t'(1);
            if ((EXP_W+2)'(shift_num_i) <= lim) begin
                ls_amt = (EXP_W+2)'(shift_num_i);   // Full normalization
            end else begin
                ls_amt = lim;                       // Stops at exponent one, subnormal
            end
            shifted = sum_i.mag << ls_amt;
            exp_n   = e - exp_ext_t'(ls_amt);
        end else begin
            ////////////////////////////////////////
            // Right shift toward a subnormal
            ////////////////////////////////////////
            rs_amt  = exp_ext_t'(1) - e;            // 1 - exp
            rs_mant = sum_i.mag >> rs_amt;
            rs_lost = ((rs_mant << rs_amt) != sum_i.mag);
            shifted = rs_mant;
            exp_n   = exp_ext_t'(1);
        end

        norm_o.sign    = sum_i.sign;
        norm_o.exp     = exp_n;
        norm_o.mant    = shifted[WIDE_W-1:CUT];     // Keep 26 bits
        norm_o.sticky  = (|shifted[CUT-1:0]) | rs_lost;
        norm_o.is_zero = sum_i.is_zero;
    end

endmodule

`default_nettype wire

//--- fma_lead_one.sv
`default_nettype none

module fma_lead_one import fma_pkg::*; (
    input  wide_mant_t mant_i,
    output shift_t     shift_num_o
);

    shift_t cnt;

    // Priority search, the highest set bit wins
    always_comb begin
        cnt = SHIFT_W'(WIDE_W);                 // All zero gives full width
        for (int i = 0; i < WIDE_W; i++) begin
            if (mant_i[i]) begin
                cnt = SHIFT_W'(WIDE_W - 1 - i); // Zeros above bit i
            end
        end
    end

    assign shift_num_o = cnt;

    // Count stays inside the accumulator and lands on the leading one
    always_comb begin
        if (!$isunknown(mant_i)) begin
            a_cnt_range: assert #0 (shift_num_o <= SHIFT_W'(WIDE_W) &&
                ((mant_i == '0) ? (shift_num_o == SHIFT_W'(WIDE_W))
                    : ((mant_i >> (WIDE_W - 1 - int'(shift_num_o))) == wide_mant_t'(1))));
        end
    end

endmodule

`default_nettype wire

//--- fma_mul_align.sv
`default_nettype none

module fma_mul_align import fma_pkg::*; (
    input  float_t a_i,
    input  float_t b_i,
    input  float_t c_i,
    output sum_s   sum_o
);

    localparam int PROD_W   = 2*(MANT_W + 1);           // 48
    localparam int PROD_LSB = WIDE_W - 1 - PROD_W;      // Product sits at [72:25]
    localparam int ADD_LSB  = WIDE_W - 1 - (MANT_W+1);  // Addend sits at [72:49]
    localparam int DIFF_W   = EXP_W + 3;

    // Hidden bit is set only for normal numbers
    function automatic logic [MANT_W:0] mant_of(input float_t f);
        return {|f[30:MANT_W], f[MANT_W-1:0]};
    endfunction

    // Subnormals and zero behave as exponent one
    function automatic logic [EXP_W-1:0] exp_of(input float_t f);
        return (f[30:MANT_W] == '0) ? EXP_W'(1) : f[30:MANT_W];
    endfunction

    logic [MANT_W:0]          ma, mb, mc;
    logic [PROD_W-1:0]        prod;
    logic signed [DIFF_W-1:0] ep, ecw, diff;
    logic [DIFF_W-1:0]        sh_amt;
    logic                     sp, sc, sub;
    logic                     prod_zero, c_zero, prod_big;
    logic                     sign_big, sign;
    wide_mant_t               prod_w, add_w, big, lesser, small_sh, mag;
    logic                     small_lost;
    logic signed [DIFF_W-1:0] exp_sel;

    always_comb begin
        ma   = mant_of(a_i);
        mb   = mant_of(b_i);
        mc   = mant_of(c_i);
        prod = ma * mb;                                 // Exact 48-bit product

        sp  = a_i[31] ^ b_i[31];
        sc  = c_i[31];
        sub = sp ^ sc;                                  // Effective subtraction

        // Exponents of the accumulator top bit for each term
        ep   = DIFF_W'(exp_of(a_i)) + DIFF_W'(exp_of(b_i)) - DIFF_W'(BIAS - 2);
        ecw  = DIFF_W'(exp_of(c_i)) + DIFF_W'(1);
        diff = ep - ecw;

        prod_w = wide_mant_t'(prod) << PROD_LSB;
        add_w  = wide_mant_t'(mc) << ADD_LSB;

        prod_zero = (prod == '0);
        c_zero    = (mc == '0);
        // A zero term must never push the other one into sticky
        prod_big  = c_zero | (!prod_zero & (diff >= 0));

        if (prod_big) begin
            big      = prod_w;
            lesser   = add_w;
            sh_amt   = diff;
            exp_sel  = ep;
            sign_big = sp;
        end else begin
            big      = add_w;
            lesser   = prod_w;
            sh_amt   = -diff;
            exp_sel  = ecw;
            sign_big = sc;
        end

        // Align the smaller term, lost bits jam into bit 0
        small_sh    = lesser >> sh_amt;
        small_lost  = ((small_sh << sh_amt) != lesser);
        small_sh[0] = small_sh[0] | small_lost;

        if (!sub) begin
            mag  = big + small_sh;                      // Bit 73 takes the carry
            sign = sign_big;
        end else if (big >= small_sh) begin
            mag  = big - small_sh;
            sign = sign_big;
        end else begin
            mag  = small_sh - big;                      // Only when nothing was shifted out
            sign = ~sign_big;
        end

        sum_o.is_zero = (mag == '0);
        sum_o.sign    = sign & ~sum_o.is_zero;          // Exact zero is +0
        sum_o.exp     = exp_ext_t'(exp_sel);
        sum_o.mag     = mag;
    end

endmodule

`default_nettype wire

//--- fma_ctrl.sv
`default_nettype none

module fma_ctrl import fma_pkg::*; (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  start_i,
    output logic ld_op_o,
    output logic ld_sum_o,
    output logic ld_norm_o,
    output logic ld_res_o,
    output logic busy_o,
    output logic done_o
);

    fma_state_e state_q, state_d;
    logic       ld_sum_q, ld_norm_q, ld_res_q;  // Enables trail the state by one cycle
    logic       done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (ld_op_o) state_d = S_ADD;
            S_ADD:   state_d = S_NORM;
            S_NORM:  state_d = S_ROUND;
            S_ROUND: state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            ld_sum_q  <= 1'b0;
            ld_norm_q <= 1'b0;
            ld_res_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            ld_sum_q  <= (state_q == S_ADD);
            ld_norm_q <= (state_q == S_NORM);
            ld_res_q  <= (state_q == S_ROUND);
            done_q    <= ld_res_q;              // Pulse with the result load
        end
    end

    // Still busy while the result load drains after S_ROUND
    assign busy_o    = (state_q != S_IDLE) | ld_res_q;
    assign ld_op_o   = start_i & ~busy_o;       // Start while busy is dropped
    assign ld_sum_o  = ld_sum_q;
    assign ld_norm_o = ld_norm_q;
    assign ld_res_o  = ld_res_q;
    assign done_o    = done_q;

    // Stage registers never load together
    a_one_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({ld_op_o, ld_sum_o, ld_norm_o, ld_res_o}));

endmodule

`default_nettype wire

//--- fma_pkg.sv
`default_nettype none

package fma_pkg;

    ////////////////////////////////////////
    // Format constants
    ////////////////////////////////////////

    localparam int EXP_W   = 8;             // Exponent field
    localparam int MANT_W  = 23;            // Fraction field
    localparam int BIAS    = 127;
    localparam int WIDE_W  = 3*MANT_W + 5;  // Accumulator, 74 bits
    localparam int SHIFT_W = 7;             // Holds 0..74
    localparam int NORM_W  = MANT_W + 3;    // Hidden + fraction + guard + round

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [31:0]               float_t;     // IEEE single
    typedef logic signed [EXP_W+1:0]   exp_ext_t;   // Biased, may go negative or past 254
    typedef logic [WIDE_W-1:0]         wide_mant_t; // Unrounded magnitude
    typedef logic [SHIFT_W-1:0]        shift_t;     // Leading zero count

    // Output of the multiply / align / add stage
    // Value is mag * 2^(exp - BIAS - (WIDE_W-1)), i.e. exp belongs to the top bit
    typedef struct packed {
        logic       sign;
        exp_ext_t   exp;
        wide_mant_t mag;
        logic       is_zero;
    } sum_s;

    // Output of the normalizer, ready for rounding
    typedef struct packed {
        logic              sign;
        exp_ext_t          exp;
        logic [NORM_W-1:0] mant;    // {hidden, fraction, guard, round}
        logic              sticky;
        logic              is_zero;
    } norm_s;

    // Control sequence
    typedef enum logic [1:0] {
        S_IDLE,
        S_ADD,
        S_NORM,
        S_ROUND
    } fma_state_e;

endpackage

`default_nettype wire
